// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OPCODE_R     = 6'h00,
        OPCODE_J     = 6'h02,
        OPCODE_BEQ   = 6'h04,
        OPCODE_BNE   = 6'h05,
        OPCODE_ADDIU = 6'h09,
        OPCODE_ORI   = 6'h0D,
        OPCODE_LUI   = 6'h0F,
        OPCODE_LB    = 6'h20,
        OPCODE_LW    = 6'h23,
        OPCODE_LBU   = 6'h24,
        OPCODE_SB    = 6'h28,
        OPCODE_SW    = 6'h2B
    } opcode_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FUNCTION_JR   = 6'h08,
        FUNCTION_ADDU = 6'h21,
        FUNCTION_SUBU = 6'h23,
        FUNCTION_AND  = 6'h24,
        FUNCTION_OR   = 6'h25,
        FUNCTION_XOR  = 6'h26,
        FUNCTION_SLT  = 6'h2A
    } function_t;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jump_index_t;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_V0   = 5'd2;

endpackage

// File: cpu_bus_pkg.sv
package cpu_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

    // A fetch from this address stops the processor
    localparam word_t HALT_ADDRESS = 32'h0000_0000;
    localparam word_t WORD_MASK    = 32'hFFFF_FFFC;

    localparam byte_en_t BYTE_EN_ALL  = 4'b1111;
    localparam byte_en_t BYTE_EN_NONE = 4'b0000;

endpackage

// File: avalon_if.sv
interface avalon_if import cpu_bus_pkg::*; ();

    word_t    address;
    logic     read;
    logic     write;
    word_t    writedata;
    byte_en_t byteenable;
    logic     waitrequest;
    word_t    readdata;

    modport master (
        output address, read, write, writedata, byteenable,
        input  waitrequest, readdata
    );

    modport slave (
        input  address, read, write, writedata, byteenable,
        output waitrequest, readdata
    );

endinterface

// File: reg_file.sv
module reg_file import mips_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != REG_ZERO) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Register zero is never written, so it keeps its reset value
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    assign v0 = regs[REG_V0];

endmodule

// File: alu.sv
module alu import mips_isa_pkg::*, cpu_bus_pkg::*; (
    input  word_t instr,
    input  word_t rs_data,
    input  word_t rt_data,
    output word_t result,
    output logic  branch_taken
);

    opcode_t   opcode;
    function_t funct;
    imm_t      imm;
    word_t     imm_sext;
    word_t     imm_zext;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = function_t'(instr[5:0]);
    assign imm    = instr[15:0];

    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    always_comb begin
        result       = '0;
        branch_taken = 1'b0;
        case (opcode)
            OPCODE_R: begin
                case (funct)
                    FUNCTION_ADDU: result = rs_data + rt_data;
                    FUNCTION_SUBU: result = rs_data - rt_data;
                    FUNCTION_AND:  result = rs_data & rt_data;
                    FUNCTION_OR:   result = rs_data | rt_data;
                    FUNCTION_XOR:  result = rs_data ^ rt_data;
                    FUNCTION_SLT: begin
                        result = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    end
                    // Jump register target passes through to the controller
                    FUNCTION_JR:   result = rs_data;
                    default:       result = '0;
                endcase
            end
            OPCODE_ADDIU: result = rs_data + imm_sext;
            OPCODE_ORI:   result = rs_data | imm_zext;
            OPCODE_LUI:   result = {imm, 16'h0000};
            OPCODE_BEQ:   branch_taken = (rs_data == rt_data);
            OPCODE_BNE:   branch_taken = (rs_data != rt_data);
            default: begin
                result       = '0;
                branch_taken = 1'b0;
            end
        endcase
    end

endmodule

// File: load_store_unit.sv
module load_store_unit import mips_isa_pkg::*, cpu_bus_pkg::*; (
    input  cpu_state_t state,
    input  word_t      instr,
    input  word_t      pc,
    input  word_t      rs_data,
    input  word_t      rt_data,
    output word_t      load_data,
    avalon_if.master   bus
);

    opcode_t    opcode;
    imm_t       imm;
    word_t      eff_addr;
    logic [1:0] lane;
    logic [7:0] load_byte;
    logic       in_exec;
    byte_en_t   lane_en;

    assign opcode   = opcode_t'(instr[31:26]);
    assign imm      = instr[15:0];
    assign eff_addr = rs_data + {{16{imm[15]}}, imm};
    assign lane     = eff_addr[1:0];
    assign lane_en  = byte_en_t'(4'b0001 << lane);

    // The data access is requested only in EXEC, MEM_ACCESS just receives it
    assign in_exec = (state == EXEC);

    always_comb begin
        bus.read       = 1'b0;
        bus.write      = 1'b0;
        bus.address    = pc;
        bus.byteenable = BYTE_EN_ALL;
        bus.writedata  = rt_data;
        case (state)
            FETCH: begin
                bus.read = (pc != HALT_ADDRESS);
            end
            EXEC, MEM_ACCESS: begin
                bus.address = eff_addr & WORD_MASK;
                case (opcode)
                    OPCODE_LW: begin
                        bus.read       = in_exec;
                        bus.byteenable = (lane == 2'b00) ? BYTE_EN_ALL : BYTE_EN_NONE;
                    end
                    OPCODE_LB, OPCODE_LBU: begin
                        bus.read       = in_exec;
                        bus.byteenable = lane_en;
                    end
                    OPCODE_SW: begin
                        bus.write      = in_exec;
                        bus.byteenable = (lane == 2'b00) ? BYTE_EN_ALL : BYTE_EN_NONE;
                    end
                    OPCODE_SB: begin
                        bus.write      = in_exec;
                        bus.byteenable = lane_en;
                        bus.writedata  = {4{rt_data[7:0]}};
                    end
                    default: begin
                        bus.byteenable = BYTE_EN_NONE;
                    end
                endcase
            end
            default: begin
                bus.byteenable = BYTE_EN_NONE;
            end
        endcase
    end

    // Read data arrives the cycle after acceptance, while in MEM_ACCESS
    assign load_byte = bus.readdata[8 * lane +: 8];

    always_comb begin
        case (opcode)
            OPCODE_LB:  load_data = {{24{load_byte[7]}}, load_byte};
            OPCODE_LBU: load_data = {24'h000000, load_byte};
            default:    load_data = bus.readdata;
        endcase
    end

endmodule

// File: cpu_control.sv
module cpu_control import mips_isa_pkg::*, cpu_bus_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      alu_result,
    input  word_t      load_data,
    input  logic       branch_taken,
    input  logic       waitrequest,
    input  word_t      readdata,
    output cpu_state_t state,
    output word_t      instr,
    output word_t      pc,
    output reg_idx_t   rs_idx,
    output reg_idx_t   rt_idx,
    output reg_idx_t   wr_idx,
    output logic       wr_en,
    output word_t      wr_data,
    output logic       active
);

    word_t       ir;
    word_t       jump_target;
    word_t       next_target;
    word_t       pc_next;
    word_t       branch_offset;
    logic        stall;
    logic        delay;
    opcode_t     opcode;
    function_t   funct;
    imm_t        imm;
    jump_index_t index;
    reg_idx_t    rd_idx;
    logic        is_load;
    logic        is_mem;
    logic        is_jr;
    logic        take;
    logic        alu_write;
    logic        exec_done;

    // First EXEC cycle decodes straight from the bus, later cycles from ir
    assign instr = (state == EXEC && !stall) ? readdata : ir;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = function_t'(instr[5:0]);
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign imm    = instr[15:0];
    assign index  = instr[25:0];

    assign is_load = (opcode == OPCODE_LW) || (opcode == OPCODE_LB) || (opcode == OPCODE_LBU);
    assign is_mem  = is_load || (opcode == OPCODE_SW) || (opcode == OPCODE_SB);
    assign is_jr   = (opcode == OPCODE_R) && (funct == FUNCTION_JR);
    assign take    = branch_taken || is_jr || (opcode == OPCODE_J);

    // Memory instructions wait in EXEC until their request is accepted
    assign exec_done = !(is_mem && waitrequest);

    assign pc_next       = pc + 32'd4;
    assign branch_offset = {{14{imm[15]}}, imm, 2'b00};

    always_comb begin
        if (opcode == OPCODE_J) begin
            next_target = {pc_next[31:28], index, 2'b00};
        end else if (is_jr) begin
            next_target = alu_result;
        end else begin
            next_target = pc_next + branch_offset;
        end
    end

    always_comb begin
        case (opcode)
            OPCODE_R: begin
                case (funct)
                    FUNCTION_ADDU, FUNCTION_SUBU, FUNCTION_AND,
                    FUNCTION_OR, FUNCTION_XOR, FUNCTION_SLT: alu_write = 1'b1;
                    default: alu_write = 1'b0;
                endcase
            end
            OPCODE_ADDIU, OPCODE_ORI, OPCODE_LUI: alu_write = 1'b1;
            default: alu_write = 1'b0;
        endcase
    end

    assign wr_idx  = (opcode == OPCODE_R) ? rd_idx : rt_idx;
    assign wr_en   = (state == EXEC && alu_write) || (state == MEM_ACCESS && is_load);
    assign wr_data = (state == MEM_ACCESS) ? load_data : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH;
            pc     <= RESET_VECTOR;
            active <= 1'b1;
            stall  <= 1'b0;
            delay  <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == HALT_ADDRESS) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    stall <= !exec_done;
                    if (exec_done) begin
                        state <= is_load ? MEM_ACCESS : FETCH;
                        // The delay slot finishes before the jump takes effect
                        pc    <= delay ? jump_target : pc_next;
                        delay <= take;
                    end
                end
                MEM_ACCESS: begin
                    state <= FETCH;
                end
                default: begin
                    state <= HALTED;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC && !stall) begin
            ir <= readdata;
        end
        if (state == EXEC && exec_done && take) begin
            jump_target <= next_target;
        end
    end

endmodule

// File: mips_cpu_bus.sv
module mips_cpu_bus import mips_isa_pkg::*, cpu_bus_pkg::*; #(
    parameter word_t RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic     clk,
    input  logic     reset,
    output logic     active,
    output word_t    register_v0,
    output word_t    address,
    output logic     write,
    output logic     read,
    input  logic     waitrequest,
    output word_t    writedata,
    output byte_en_t byteenable,
    input  word_t    readdata
);

    avalon_if bus ();

    cpu_state_t state;
    word_t      instr;
    word_t      pc;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    word_t      load_data;
    word_t      wr_data;
    logic       branch_taken;
    logic       wr_en;
    reg_idx_t   rs_idx;
    reg_idx_t   rt_idx;
    reg_idx_t   wr_idx;

    // Memory side of the bus
    assign address         = bus.address;
    assign read            = bus.read;
    assign write           = bus.write;
    assign writedata       = bus.writedata;
    assign byteenable      = bus.byteenable;
    assign bus.waitrequest = waitrequest;
    assign bus.readdata    = readdata;

    reg_file reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    alu alu_i (
        .instr        (instr),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    load_store_unit load_store_unit_i (
        .state     (state),
        .instr     (instr),
        .pc        (pc),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .load_data (load_data),
        .bus       (bus.master)
    );

    cpu_control #(
        .RESET_VECTOR (RESET_VECTOR)
    ) cpu_control_i (
        .clk          (clk),
        .reset        (reset),
        .alu_result   (alu_result),
        .load_data    (load_data),
        .branch_taken (branch_taken),
        .waitrequest  (bus.waitrequest),
        .readdata     (bus.readdata),
        .state        (state),
        .instr        (instr),
        .pc           (pc),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .wr_idx       (wr_idx),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .active       (active)
    );

endmodule

// File: mips_cpu_bus_assertions.sv
module mips_cpu_bus_assertions import cpu_bus_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     active,
    input logic     read,
    input logic     write,
    input logic     waitrequest,
    input word_t    address,
    input word_t    writedata,
    input byte_en_t byteenable
);

    int failures = 0;

    read_write_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    ) else begin
        $error("read and write are high in the same cycle");
        failures++;
    end

    request_aligned: assert property (
        @(posedge clk) disable iff (reset) (read || write) |-> (address[1:0] == 2'b00)
    ) else begin
        $error("request address %h is not word aligned", address);
        failures++;
    end

    // A stalled request keeps its address, lanes and data until accepted
    read_held: assert property (
        @(posedge clk) disable iff (reset)
        (read && waitrequest) |=> (read && $stable(address) && $stable(byteenable))
    ) else begin
        $error("read request changed while waitrequest was high");
        failures++;
    end

    write_held: assert property (
        @(posedge clk) disable iff (reset)
        (write && waitrequest) |=>
            (write && $stable(address) && $stable(byteenable) && $stable(writedata))
    ) else begin
        $error("write request changed while waitrequest was high");
        failures++;
    end

    idle_when_halted: assert property (
        @(posedge clk) disable iff (reset) !active |-> (!read && !write)
    ) else begin
        $error("bus request issued while the processor is halted");
        failures++;
    end

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions assertions_i (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable)
);

// File: mips_cpu_bus_tb.sv
module mips_cpu_bus_tb import cpu_bus_pkg::*; ();

    localparam int CYCLES_PER_WORD = 40;
    localparam int CYCLES_BASE     = 200;
    localparam int HALT_WATCH      = 10;

    typedef struct packed {
        word_t    address;
        byte_en_t byteenable;
        word_t    data;
    } bus_write_t;

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    logic     waitrequest = 1'b0;
    word_t    readdata = '0;
    logic     active;
    word_t    register_v0;
    word_t    address;
    logic     write;
    logic     read;
    word_t    writedata;
    byte_en_t byteenable;

    word_t      memory [word_t];
    bus_write_t expected_writes [$];
    word_t      expected_v0;
    integer     seed = 95327;
    int         cycle_count = 0;
    int         cycle_limit = 0;

    mips_cpu_bus #(
        .RESET_VECTOR (32'hBFC0_0000)
    ) mips_cpu_bus_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    always #5 clk = ~clk;

    task automatic report_failure(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERR time=%0t %s got %h expected %h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic check_write(word_t addr, byte_en_t be, word_t data);
        bus_write_t expected;
        if (expected_writes.size() == 0) begin
            report_failure($sformatf("unexpected bus write to address %h", addr));
        end else begin
            expected = expected_writes.pop_front();
            check_word("address", addr, expected.address);
            if (be !== expected.byteenable) begin
                report_failure($sformatf("ERR time=%0t byteenable got %h expected %h",
                                         $time, be, expected.byteenable));
            end
            check_word("writedata", data, expected.data);
        end
    endtask

    // Words never loaded or written read back a pattern of their address
    function automatic word_t read_word(word_t addr);
        word_t value;
        if (memory.exists(addr)) begin
            value = memory[addr];
        end else begin
            value = addr ^ 32'hDEAD_BEEF;
        end
        return value;
    endfunction

    task automatic merge_write(word_t addr, byte_en_t be, word_t data);
        word_t merged;
        merged = read_word(addr);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8 * i +: 8] = data[8 * i +: 8];
            end
        end
        memory[addr] = merged;
    endtask

    function automatic logic random_stall();
        bit [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic load_trace();
        int    fd;
        int    m_count;
        bit    have_v0;
        string line;
        word_t field_a;
        word_t field_b;
        word_t field_c;
        m_count = 0;
        have_v0 = 1'b0;
        fd = $fopen("mips_cpu_bus_trace.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open mips_cpu_bus_trace.txt");
        end
        // Lines that start with any other character are comments
        while ($fgets(line, fd) != 0) begin
            case (line.getc(0))
                "M": begin
                    if ($sscanf(line.substr(1, line.len() - 1), "%h %h",
                                field_a, field_b) != 2) begin
                        report_failure("malformed M record in the trace file");
                    end
                    memory[field_a] = field_b;
                    m_count++;
                end
                "W": begin
                    if ($sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                                field_a, field_b, field_c) != 3) begin
                        report_failure("malformed W record in the trace file");
                    end
                    expected_writes.push_back('{field_a, byte_en_t'(field_b), field_c});
                end
                "V": begin
                    if ($sscanf(line.substr(1, line.len() - 1), "%h", field_a) != 1) begin
                        report_failure("malformed V record in the trace file");
                    end
                    expected_v0 = field_a;
                    have_v0 = 1'b1;
                end
                default: begin
                end
            endcase
        end
        $fclose(fd);
        if (!have_v0) begin
            report_failure("trace file has no expected register_v0");
        end
        cycle_limit = CYCLES_PER_WORD * m_count + CYCLES_BASE;
    endtask

    // Memory answers a read the cycle after acceptance and stalls at random
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b0;
        end else begin
            if (read && !waitrequest) begin
                readdata <= read_word(address);
            end
            if (write && !waitrequest) begin
                check_write(address, byteenable, writedata);
                merge_write(address, byteenable, writedata);
            end
            waitrequest <= random_stall();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            report_failure($sformatf("timeout, processor did not halt within %0d cycles",
                                     cycle_limit));
        end
        if (mips_cpu_bus_i.assertions_i.failures != 0) begin
            report_failure("a bus protocol assertion failed");
        end
    end

    initial begin
        load_trace();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // Run until the fetch from the halt address drops active
        do begin
            @(posedge clk);
        end while (active);
        repeat (HALT_WATCH) begin
            @(posedge clk);
            if (read || write || active) begin
                report_failure("bus request or active seen after the processor halted");
            end
        end
        if (expected_writes.size() != 0) begin
            report_failure($sformatf("%0d expected bus writes never happened",
                                     expected_writes.size()));
        end
        check_word("register_v0", register_v0, expected_v0);
        if (mips_cpu_bus_i.assertions_i.failures != 0) begin
            report_failure("a bus protocol assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: mips_cpu_bus_trace.txt
# Columns are M address word for initial memory
# W address byteenable data for each expected bus write in order, V word for final register_v0
# Arithmetic chain LUI ORI ADDIU ADDU SUBU AND OR XOR SLT
M BFC00000 3C081234
M BFC00004 35085678
M BFC00008 2409FFFD
M BFC0000C 01095821
M BFC00010 01096023
M BFC00014 016C6824
M BFC00018 016C7025
M BFC0001C 01AE7826
M BFC00020 0128802A
M BFC00024 0109882A
M BFC00028 01F01021
# Stores with base 0x1000 in r10
M BFC0002C 340A1000
M BFC00030 AD480000
M BFC00034 A14B0005
M BFC00038 AD4B0002
M BFC0003C A14C000B
# Loads LB LBU LW LB then stores that reveal them
M BFC00040 81520011
M BFC00044 91530013
M BFC00048 8D540010
M BFC0004C 8155000B
M BFC00050 AD520020
M BFC00054 AD530024
M BFC00058 AD540028
M BFC0005C 00551021
# Taken BEQ, not taken BNE, J, then JR r0 to halt
M BFC00060 24170001
M BFC00064 24180055
M BFC00068 10000002
M BFC0006C 24190011
M BFC00070 AD580030
M BFC00074 AD590034
M BFC00078 16F70002
M BFC0007C 241A0022
M BFC00080 AD5A0038
M BFC00084 0BF00024
M BFC00088 24420100
M BFC0008C AD58003C
M BFC00090 AD420040
M BFC00094 00000008
M BFC00098 24420001
M 00001010 80F0A5C3
W 00001000 F 12345678
W 00001004 2 75757575
W 00001000 0 12345675
W 00001008 8 7B7B7B7B
W 00001020 F FFFFFFA5
W 00001024 F 00000080
W 00001028 F 80F0A5C3
W 00001034 F 00000011
W 00001038 F 00000022
W 00001040 F 0000018A
V 0000018B

// File: mips_cpu_bus.f
mips_isa_pkg.sv
cpu_bus_pkg.sv
avalon_if.sv
reg_file.sv
alu.sv
load_store_unit.sv
cpu_control.sv
mips_cpu_bus.sv
mips_cpu_bus_assertions.sv
mips_cpu_bus_tb.sv

// File: Makefile
TOP := mips_cpu_bus_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and look for the pass line"
	@echo "  clean  remove the obj_dir build folder"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f mips_cpu_bus.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
